// File: common/qspi_defs.svh
`ifndef QSPI_DEFS_SVH
`define QSPI_DEFS_SVH

// Widths of the CPU-side fields
`define QSPI_ADDR_W 24
`define QSPI_DATA_W 32
`define QSPI_LEN_W  6           // Transfer length in bits

// Command bytes understood by the serial RAM
`define QSPI_CMD_WRITE      8'h38   // Quad write
`define QSPI_CMD_READ       8'hEB   // Quad fast read

// Switches the RAM from SPI to QPI mode.
// Goes out once after reset on IO0, most significant bit first
`define QSPI_CMD_ENTER_QUAD 8'h35

// SPI clocks with the bus released between address and read data
`define QSPI_DUMMY_CLKS 6

`endif

// File: common/qspi_pkg.sv
`default_nettype none
`include "qspi_defs.svh"

package qspi_pkg;

    // Sequencer phases
    typedef enum logic [3:0] {
        ph_idle,
        ph_quad_enter_start,    // CS low, clock still parked
        ph_quad_enter,          // 0x35 bit by bit on IO0
        ph_quad_enter_end,      // CS high again
        ph_send_cmd,
        ph_send_addr,
        ph_dummy,
        ph_data,
        ph_done
    } qspi_phase_e;

    // What the shifter loads into its outgoing register
    typedef enum logic [2:0] {
        ld_none,
        ld_enter_cmd,
        ld_cmd_addr,
        ld_write_data,
        ld_clear                // Also empties the incoming register
    } qspi_load_e;

    // Control word from the sequencer, one per system clock
    typedef struct packed {
        logic       cs_n;
        logic       clk_en;     // SPI clock running
        logic [3:0] oe;
        logic       serial;     // One bit on IO0 instead of a nibble
        qspi_load_e load;
        logic       shift_out;  // Advance outgoing register on fall tick
        logic       shift_in;   // Take a nibble on rise tick
        logic       capture;    // Copy incoming register to data_out
    } qspi_ctrl_t;

endpackage

`default_nettype wire

// File: hw/qspi/qspi_pin_driver.sv
`timescale 1ns/1ps
`default_nettype none

module qspi_pin_driver (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire qspi_pkg::qspi_ctrl_t ctrl,
    input  wire logic [3:0]           out_nibble,
    input  wire logic [3:0]           spi_io_in,
    output logic [3:0]                io_in,
    output logic                      fall_tick,
    output logic                      rise_tick,
    output logic                      spi_clk,
    output logic                      spi_cs_n,
    output logic [3:0]                spi_io_out,
    output logic [3:0]                spi_io_oe
);

    // High in the half where the next nibble is launched
    logic write_phase;

    assign fall_tick = ctrl.clk_en & write_phase;
    assign rise_tick = ctrl.clk_en & ~write_phase;
    assign io_in     = spi_io_in;   // Sampled by the shifter on rise_tick

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_phase <= 1'b1;
            spi_clk     <= 1'b0;
            spi_cs_n    <= 1'b1;
            spi_io_oe   <= 4'h0;
            spi_io_out  <= 4'h0;
        end else begin
            // First half after enable is always a launch half
            write_phase <= ctrl.clk_en ? ~write_phase : 1'b1;

            // Low while data changes, high once it has been sampled
            spi_clk <= rise_tick;

            spi_cs_n  <= ctrl.cs_n;
            spi_io_oe <= ctrl.oe;

            if (fall_tick) begin
                spi_io_out <= out_nibble;
            end else if (!ctrl.clk_en) begin
                spi_io_out <= 4'h0;     // Park low between frames
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/qspi/qspi_sequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "qspi_defs.svh"

module qspi_sequencer (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  start,
    input  wire logic                  stop,
    input  wire logic                  write_enable,
    input  wire logic [`QSPI_LEN_W-1:0] data_len,
    input  wire logic                  fall_tick,
    input  wire logic                  rise_tick,
    output qspi_pkg::qspi_ctrl_t       ctrl,
    output logic                       done
);

    import qspi_pkg::*;

    typedef logic [`QSPI_LEN_W-1:0] cnt_t;

    localparam cnt_t CMD_BITS   = cnt_t'(8);
    localparam cnt_t ADDR_BITS  = cnt_t'(`QSPI_ADDR_W);
    localparam cnt_t DUMMY_CLKS = cnt_t'(`QSPI_DUMMY_CLKS);

    qspi_phase_e phase;
    qspi_phase_e phase_nx;
    cnt_t        cnt;           // Bits sent or taken in the current phase
    cnt_t        step;
    logic        tick;
    logic        quad_mode;     // RAM already switched to QPI

    // Which tick advances the counter, and by how much
    always_comb begin
        tick = 1'b0;
        step = cnt_t'(4);
        case (phase)
            ph_quad_enter: begin
                tick = fall_tick;
                step = cnt_t'(1);
            end
            ph_send_cmd, ph_send_addr: tick = fall_tick;
            ph_dummy: begin
                tick = fall_tick;
                step = cnt_t'(1);   // Counts SPI clocks here
            end
            ph_data:  tick = write_enable ? fall_tick : rise_tick;
            default:  tick = 1'b0;
        endcase
    end

    always_comb begin
        phase_nx = phase;
        case (phase)
            ph_idle: begin
                if (start) begin
                    phase_nx = quad_mode ? ph_send_cmd : ph_quad_enter_start;
                end
            end
            ph_quad_enter_start: phase_nx = ph_quad_enter;
            ph_quad_enter: begin
                if (cnt == CMD_BITS) phase_nx = ph_quad_enter_end;
            end
            ph_quad_enter_end:   phase_nx = ph_send_cmd;
            ph_send_cmd: begin
                if (cnt == CMD_BITS) phase_nx = ph_send_addr;
            end
            ph_send_addr: begin
                if (cnt == ADDR_BITS) phase_nx = write_enable ? ph_data : ph_dummy;
            end
            ph_dummy: begin
                if (cnt == DUMMY_CLKS) phase_nx = ph_data;
            end
            ph_data: begin
                if (cnt == data_len) phase_nx = ph_done;
            end
            default: phase_nx = ph_idle;    // ph_done included
        endcase
        if (stop) phase_nx = ph_idle;       // Abort from anywhere
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= ph_idle;
            cnt       <= '0;
            quad_mode <= 1'b0;
            done      <= 1'b0;
        end else begin
            phase <= phase_nx;
            done  <= (phase == ph_done) && !stop;   // Lines up with data_out
            if (phase_nx != phase) begin
                cnt <= '0;
            end else if (tick) begin
                cnt <= cnt + step;
            end
            if (phase == ph_quad_enter && phase_nx == ph_quad_enter_end) begin
                quad_mode <= 1'b1;
            end
        end
    end

    // Control word for shifter and pin driver
    always_comb begin
        ctrl      = '0;
        ctrl.cs_n = 1'b1;
        ctrl.load = ld_none;
        case (phase)
            ph_idle: begin
                if (start) begin
                    // CS falls on the next clock, load the first frame now
                    ctrl.cs_n = 1'b0;
                    ctrl.oe   = quad_mode ? 4'hf : 4'h1;
                    ctrl.load = quad_mode ? ld_cmd_addr : ld_enter_cmd;
                end
            end
            ph_quad_enter_start: begin
                ctrl.cs_n   = 1'b0;
                ctrl.oe     = 4'h1;
                ctrl.serial = 1'b1;
            end
            ph_quad_enter: begin
                ctrl.cs_n      = 1'b0;
                ctrl.clk_en    = 1'b1;
                ctrl.oe        = 4'h1;
                ctrl.serial    = 1'b1;
                ctrl.shift_out = 1'b1;
            end
            ph_quad_enter_end: ctrl.load = ld_cmd_addr;
            ph_send_cmd: begin
                ctrl.cs_n      = 1'b0;
                ctrl.clk_en    = 1'b1;
                ctrl.oe        = 4'hf;
                ctrl.shift_out = 1'b1;
            end
            ph_send_addr: begin
                ctrl.cs_n      = 1'b0;
                ctrl.clk_en    = 1'b1;
                ctrl.oe        = 4'hf;
                ctrl.shift_out = 1'b1;
                if (cnt == ADDR_BITS) begin
                    ctrl.load = write_enable ? ld_write_data : ld_clear;
                end
            end
            ph_dummy: begin
                ctrl.cs_n   = 1'b0;
                ctrl.clk_en = 1'b1;     // Bus released
            end
            ph_data: begin
                ctrl.cs_n      = 1'b0;
                ctrl.clk_en    = 1'b1;
                ctrl.oe        = write_enable ? 4'hf : 4'h0;
                ctrl.shift_out = write_enable;
                ctrl.shift_in  = !write_enable;
            end
            ph_done: ctrl.capture = 1'b1;
            default: ctrl.cs_n = 1'b1;
        endcase
        if (stop) begin
            ctrl      = '0;
            ctrl.cs_n = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/qspi/qspi_shifter.sv
`timescale 1ns/1ps
`default_nettype none
`include "qspi_defs.svh"

module qspi_shifter (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire qspi_pkg::qspi_ctrl_t   ctrl,
    input  wire logic                   fall_tick,
    input  wire logic                   rise_tick,
    input  wire logic                   write_enable,
    input  wire logic [`QSPI_ADDR_W-1:0] addr,
    input  wire logic [`QSPI_DATA_W-1:0] data_in,
    input  wire logic [3:0]             io_in,
    output logic [3:0]                  out_nibble,
    output logic [`QSPI_DATA_W-1:0]     data_out
);

    import qspi_pkg::*;

    localparam int DW = `QSPI_DATA_W;

    logic [DW-1:0] out_reg;     // MSB goes out first
    logic [DW-1:0] in_reg;
    logic [7:0]    cmd_byte;

    assign cmd_byte   = write_enable ? `QSPI_CMD_WRITE : `QSPI_CMD_READ;
    assign out_nibble = ctrl.serial ? {3'b000, out_reg[DW-1]} : out_reg[DW-1:DW-4];

    always_ff @(posedge clk) begin
        case (ctrl.load)
            ld_enter_cmd:  out_reg <= {`QSPI_CMD_ENTER_QUAD, {(DW-8){1'b0}}};
            ld_cmd_addr:   out_reg <= {cmd_byte, addr};
            ld_write_data: out_reg <= data_in;
            ld_clear:      out_reg <= '0;
            default: begin
                if (fall_tick && ctrl.shift_out) begin
                    if (ctrl.serial) begin
                        out_reg <= {out_reg[DW-2:0], 1'b0};
                    end else begin
                        out_reg <= {out_reg[DW-5:0], 4'h0};
                    end
                end
            end
        endcase

        // Read data builds up right-aligned
        if (ctrl.load == ld_clear) begin
            in_reg <= '0;
        end else if (rise_tick && ctrl.shift_in) begin
            in_reg <= {in_reg[DW-5:0], io_in};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (ctrl.capture) begin
            data_out <= write_enable ? '0 : in_reg;     // Writes report zero
        end
    end

endmodule

`default_nettype wire

// File: hw/qspi_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "qspi_defs.svh"

module qspi_master (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   start,
    input  wire logic                   stop,
    input  wire logic                   write_enable,
    input  wire logic [`QSPI_ADDR_W-1:0] addr,
    input  wire logic [`QSPI_LEN_W-1:0]  data_len,
    input  wire logic [`QSPI_DATA_W-1:0] data_in,
    output logic [`QSPI_DATA_W-1:0]     data_out,
    output logic                        done,
    output logic                        spi_clk,
    output logic                        spi_cs_n,
    input  wire logic [3:0]             spi_io_in,
    output logic [3:0]                  spi_io_out,
    output logic [3:0]                  spi_io_oe
);

    import qspi_pkg::*;

    qspi_ctrl_t ctrl;
    logic       fall_tick;
    logic       rise_tick;
    logic [3:0] out_nibble;
    logic [3:0] io_in;

    // Phase control and done pulse
    qspi_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .stop         (stop),
        .write_enable (write_enable),
        .data_len     (data_len),
        .fall_tick    (fall_tick),
        .rise_tick    (rise_tick),
        .ctrl         (ctrl),
        .done         (done)
    );

    qspi_shifter u_shifter (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .fall_tick    (fall_tick),
        .rise_tick    (rise_tick),
        .write_enable (write_enable),
        .addr         (addr),
        .data_in      (data_in),
        .io_in        (io_in),
        .out_nibble   (out_nibble),
        .data_out     (data_out)
    );

    // Pins and SPI clock
    qspi_pin_driver u_pin_driver (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .out_nibble (out_nibble),
        .spi_io_in  (spi_io_in),
        .io_in      (io_in),
        .fall_tick  (fall_tick),
        .rise_tick  (rise_tick),
        .spi_clk    (spi_clk),
        .spi_cs_n   (spi_cs_n),
        .spi_io_out (spi_io_out),
        .spi_io_oe  (spi_io_oe)
    );

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the QSPI master testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_qspi_master \
    -Mdir obj_dir -o tb_qspi_master

./obj_dir/tb_qspi_master > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a verdict, see sim.log"
    exit 1
fi
echo "Simulation passed"

// File: tests/qspi_ram_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "qspi_defs.svh"

module qspi_ram_model (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       spi_clk,
    input  wire logic       spi_cs_n,
    input  wire logic [3:0] spi_io_out,
    input  wire logic [3:0] spi_io_oe,
    output logic [3:0]      spi_io_in,
    output int              enter_count,
    output int              error_count
);

    localparam int MEM_DEPTH  = 65536;                  // Nibbles, low address bits only
    localparam int DRIVE_FROM = 8 + `QSPI_DUMMY_CLKS;   // Last dummy rise

    logic [3:0]  mem [0:MEM_DEPTH-1];
    logic        qpi;           // Enter-quad seen
    logic        clk_q;
    logic        cs_q;
    int          rises;         // SPI clock rises in the current frame
    logic [7:0]  cmd;
    logic [23:0] addr_sr;
    logic [7:0]  serial_byte;

    function automatic logic [3:0] fill_nibble(input logic [15:0] idx);
        return idx[3:0] ^ idx[7:4] ^ idx[11:8] ^ idx[15:12] ^ 4'h9;
    endfunction

    // Nibbles of a byte address start at twice that address
    function automatic logic [15:0] nib_index(input logic [23:0] a, input int k);
        logic [24:0] na;
        na = {a, 1'b0} + 25'(k);
        return na[15:0];
    endfunction

    initial begin
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[16'(i)] = fill_nibble(16'(i));
        end
    end

    // Pins are oversampled, so each value seen here is the one of the last cycle
    always @(posedge clk or negedge rst_n) begin
        int         n;
        int         errs;
        logic [3:0] oe_exp;
        if (!rst_n) begin
            qpi         <= 1'b0;
            clk_q       <= 1'b0;
            cs_q        <= 1'b1;
            rises       <= 0;
            cmd         <= 8'h00;
            addr_sr     <= '0;
            serial_byte <= 8'h00;
            spi_io_in   <= 4'h0;
            enter_count <= 0;
            error_count <= 0;
        end else begin
            errs   = 0;
            n      = rises + 1;
            oe_exp = qpi ? 4'hf : 4'h1;
            clk_q <= spi_clk;
            cs_q  <= spi_cs_n;
            if (spi_cs_n) begin
                rises     <= 0;
                spi_io_in <= 4'h0;
                if (!cs_q && !qpi) begin    // End of a serial frame
                    if (rises == 8 && serial_byte == `QSPI_CMD_ENTER_QUAD) begin
                        qpi         <= 1'b1;
                        enter_count <= enter_count + 1;
                    end else begin
                        $display("RAM model: serial frame was not a complete enter-quad command");
                        errs++;
                    end
                end
            end else if (spi_clk && !clk_q) begin
                rises <= n;
                if (!qpi) begin
                    serial_byte <= {serial_byte[6:0], spi_io_out[0]};
                end else if (n <= 2) begin
                    cmd <= {cmd[3:0], spi_io_out};
                end else if (n <= 8) begin
                    addr_sr <= {addr_sr[19:0], spi_io_out};
                end else if (cmd == `QSPI_CMD_WRITE) begin
                    mem[nib_index(addr_sr, n - 9)] <= spi_io_out;
                end else begin
                    oe_exp = 4'h0;  // Bus released in dummy and read data
                    // Next nibble goes out one SPI clock ahead of its sample edge
                    if (n >= DRIVE_FROM) begin
                        spi_io_in <= mem[nib_index(addr_sr, n - DRIVE_FROM)];
                    end
                end
                if (qpi && n == 3 && cmd != `QSPI_CMD_WRITE && cmd != `QSPI_CMD_READ) begin
                    $display("RAM model: unknown command byte %h", cmd);
                    errs++;
                end
                if (spi_io_oe != oe_exp) begin
                    $display("RAM model: output enables were %h at SPI clock %0d, not %h",
                             spi_io_oe, n, oe_exp);
                    errs++;
                end
            end
            error_count <= error_count + errs;
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_qspi_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "qspi_defs.svh"

module tb_qspi_master;

    localparam int ACCESS_LIMIT = 100;      // Longest access takes about 60 clocks
    localparam int RUN_LIMIT    = 6000;     // About 51 accesses of at most 90 clocks

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic                    stop;
    logic                    write_enable;
    logic [`QSPI_ADDR_W-1:0] addr;
    logic [`QSPI_LEN_W-1:0]  data_len;
    logic [`QSPI_DATA_W-1:0] data_in;
    logic [`QSPI_DATA_W-1:0] data_out;
    logic                    done;
    logic                    spi_clk;
    logic                    spi_cs_n;
    logic [3:0]              spi_io_in;
    logic [3:0]              spi_io_out;
    logic [3:0]              spi_io_oe;
    int                      enter_count;
    int                      model_errors;
    int                      errors = 0;
    int                      checks = 0;
    int                      cycle_count = 0;

    qspi_master UUT (.*);

    qspi_ram_model u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .spi_clk     (spi_clk),
        .spi_cs_n    (spi_cs_n),
        .spi_io_out  (spi_io_out),
        .spi_io_oe   (spi_io_oe),
        .spi_io_in   (spi_io_in),
        .enter_count (enter_count),
        .error_count (model_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == RUN_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", RUN_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [`QSPI_ADDR_W-1:0] random_addr();
        logic [31:0] r;
        r = $urandom;
        return r[`QSPI_ADDR_W-1:0];
    endfunction

    task automatic issue_start(input logic we, input logic [`QSPI_ADDR_W-1:0] a,
                               input logic [`QSPI_LEN_W-1:0] len, input logic [31:0] d);
        @(posedge clk);
        start        <= 1'b1;
        write_enable <= we;
        addr         <= a;
        data_len     <= len;
        data_in      <= d;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input string name, output logic [31:0] result);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        result = '0;
        while (!seen && waited < ACCESS_LIMIT) begin
            @(negedge clk);     // Outputs are stable here
            if (done) begin
                seen   = 1'b1;
                result = data_out;
            end else begin
                waited++;
            end
        end
        if (!seen) begin
            errors++;
            $display("%s: no done within %0d cycles", name, ACCESS_LIMIT);
        end
    endtask

    task automatic run_access(input string name, input logic we,
                              input logic [`QSPI_ADDR_W-1:0] a,
                              input logic [`QSPI_LEN_W-1:0] len,
                              input logic [31:0] d, output logic [31:0] result);
        issue_start(we, a, len, d);
        wait_done(name, result);
    endtask

    // Only the top len bits go out, so the read comes back right-aligned
    task automatic write_then_read(input string name, input logic [`QSPI_ADDR_W-1:0] a,
                                   input logic [`QSPI_LEN_W-1:0] len, input logic [31:0] d);
        logic [31:0] result;
        run_access({name, " write"}, 1'b1, a, len, d, result);
        check_value({name, " write data_out"}, 32'd0, result);
        run_access({name, " read"}, 1'b0, a, len, 32'd0, result);
        check_value({name, " read"}, d >> (32 - len), result);
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        check_value("idle spi_cs_n", 32'd1, 32'(spi_cs_n));
        check_value("idle spi_io_oe", 32'd0, 32'(spi_io_oe));
        check_value("idle spi_clk", 32'd0, 32'(spi_clk));
        check_value("idle done", 32'd0, 32'(done));
    endtask

    task automatic short_length_round_trips();
        write_then_read("len4", random_addr(), 6'd4, $urandom);
        write_then_read("len8", random_addr(), 6'd8, $urandom);
        write_then_read("len16", random_addr(), 6'd16, $urandom);
    endtask

    task automatic stop_aborts_read();
        logic [`QSPI_ADDR_W-1:0] a;
        logic [31:0]             d;
        logic [31:0]             result;
        logic                    seen;
        logic                    late_done;
        int                      waited;
        a = random_addr();
        d = $urandom;
        run_access("stop_setup write", 1'b1, a, 6'd32, d, result);
        issue_start(1'b0, a, 6'd32, 32'd0);
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < ACCESS_LIMIT) begin
            @(negedge clk);
            seen = !spi_cs_n && spi_io_oe == 4'h0;  // Dummy clocks have begun
            waited++;
        end
        if (!seen) begin
            errors++;
            $display("stop_read: the read never reached its dummy clocks");
        end
        @(posedge clk);
        stop <= 1'b1;
        @(posedge clk);
        stop <= 1'b0;
        @(negedge clk);
        check_value("stop spi_cs_n", 32'd1, 32'(spi_cs_n));
        check_value("stop spi_io_oe", 32'd0, 32'(spi_io_oe));
        late_done = 1'b0;
        repeat (100) begin
            @(negedge clk);
            if (done) late_done = 1'b1;
        end
        check_value("stop no done", 32'd0, 32'(late_done));
        run_access("stop_reread", 1'b0, a, 6'd32, 32'd0, result);
        check_value("stop_reread", d, result);
    endtask

    task automatic mixed_round_trips();
        logic [`QSPI_LEN_W-1:0] len;
        for (int i = 0; i < 20; i++) begin
            len = 6'((($urandom % 8) + 1) * 4);
            write_then_read($sformatf("random_%0d", i), random_addr(), len, $urandom);
        end
    endtask

    initial begin
        void'($urandom(32'ha9f4dbdb));
        rst_n        = 1'b0;
        start        = 1'b0;
        stop         = 1'b0;
        write_enable = 1'b0;
        addr         = '0;
        data_len     = '0;
        data_in      = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        idle_after_reset();
        write_then_read("full_word", random_addr(), 6'd32, $urandom);
        short_length_round_trips();
        stop_aborts_read();
        mixed_round_trips();
        check_value("enter_quad count", 32'd1, 32'(enter_count));

        $display("Checks: %0d, testbench errors: %0d, RAM model errors: %0d",
                 checks, errors, model_errors);
        if (errors == 0 && model_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+common
common/qspi_pkg.sv
hw/qspi/qspi_sequencer.sv
hw/qspi/qspi_shifter.sv
hw/qspi/qspi_pin_driver.sv
hw/qspi_master.sv
tests/qspi_ram_model.sv
tests/tb_qspi_master.sv
